// File: list.f
design/dcache_pkg.sv
design/way_if.sv
design/lru_policy.sv
design/dcache_ways.sv
design/dcache_ctrl.sv
design/dcache_top.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/way_if.sv
      - design/lru_policy.sv
      - design/dcache_ways.sv
      - design/dcache_ctrl.sv
      - design/dcache_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_mem_model.sv
      - testbench/tb_dcache.sv

// File: testbench/tb_dcache.sv
module tb_dcache;
        timeunit 1ns;
        timeprecision 100ps;

        import dcache_pkg::*;

        localparam int     NUM_LINES   = 64;    // backing memory, 8 tags per set
        localparam int     NUM_WORDS   = NUM_LINES * BEATS;
        localparam int     STALL_PCT   = 25;
        localparam integer SEED        = 32'h539e_59ee;
        localparam int     NUM_REQS    = 45;    // sum over the six tests
        localparam int     MISS_CYCLES = 40;    // dirty miss with memory stalls
        localparam int     CYCLE_LIMIT = 20 * NUM_REQS * MISS_CYCLES;

        logic        clk;
        logic        rst;
        logic        i_cpu_req_valid, i_cpu_req_we, o_cpu_req_ready;
        logic [31:0] i_cpu_req_addr, i_cpu_req_wdata;
        logic [3:0]  i_cpu_req_wstrb;
        logic        o_cpu_rsp_valid, i_cpu_rsp_ready;
        logic [31:0] o_cpu_rsp_data;
        logic        o_mem_rd_req_valid, i_mem_rd_req_ready;
        logic        i_mem_rd_rsp_valid, i_mem_rd_rsp_last, o_mem_rd_rsp_ready;
        logic [31:0] o_mem_rd_req_addr, i_mem_rd_rsp_data;
        logic        o_mem_wr_req_valid, i_mem_wr_req_ready;
        logic        o_mem_wr_data_valid, o_mem_wr_data_last, i_mem_wr_data_ready;
        logic [31:0] o_mem_wr_req_addr, o_mem_wr_data;

        logic [31:0] shadow [NUM_WORDS];
        integer      seed;
        int          rd_count;
        int          cycles   = 0;
        int          wb_count = 0;
        logic [31:0] wb_addr;
        logic [2:0]  wb_beat;
        line_t       wb_line;
        logic [31:0] cur_addr = '0;     // address of the request in flight

        tb_clock u_clock (
                .o_clk (clk),
                .o_rst (rst)
        );

        dcache_top uut (.*);

        tb_mem_model #(
                .NUM_LINES (NUM_LINES),
                .STALL_PCT (STALL_PCT),
                .SEED      (SEED)
        ) u_mem (
                .clk             (clk),
                .rst             (rst),
                .i_rd_req_valid  (o_mem_rd_req_valid),
                .i_rd_req_addr   (o_mem_rd_req_addr),
                .o_rd_req_ready  (i_mem_rd_req_ready),
                .o_rd_rsp_valid  (i_mem_rd_rsp_valid),
                .o_rd_rsp_data   (i_mem_rd_rsp_data),
                .o_rd_rsp_last   (i_mem_rd_rsp_last),
                .i_rd_rsp_ready  (o_mem_rd_rsp_ready),
                .i_wr_req_valid  (o_mem_wr_req_valid),
                .i_wr_req_addr   (o_mem_wr_req_addr),
                .o_wr_req_ready  (i_mem_wr_req_ready),
                .i_wr_data_valid (o_mem_wr_data_valid),
                .i_wr_data       (o_mem_wr_data),
                .o_wr_data_ready (i_mem_wr_data_ready),
                .o_rd_count      (rd_count)
        );

        function automatic int word_index(input logic [31:0] addr);
                return int'(addr[2 +: $clog2(NUM_WORDS)]);
        endfunction

        // reference model of a cached read
        function automatic logic [31:0] expected_word(input logic [31:0] addr);
                return shadow[word_index(addr)];
        endfunction

        function automatic line_t shadow_line(input logic [31:0] addr);
                line_t l;
                for (int b = 0; b < BEATS; b++) begin
                        l.words[b] = shadow[word_index(addr) + b];
                end
                return l;
        endfunction

        function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                    input logic [31:0] new_w,
                                                    input logic [3:0]  strb);
                logic [31:0] res;
                res = old_w;
                for (int b = 0; b < 4; b++) begin
                        if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
                end
                return res;
        endfunction

        // memory tag sits above the 3 index bits
        function automatic logic [31:0] addr_of(input int tag, input int index, input int word);
                return 32'((tag << 8) | (index << 5) | (word << 2));
        endfunction

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Finished with errors");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_word(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
                if (act !== exp) begin
                        $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
                        abort_run("read data or address mismatch");
                end
        endtask

        task automatic check_count(input string name, input int exp, input int act);
                if (act != exp) begin
                        $display("CHECK FAILED %s: expected %0d, got %0d", name, exp, act);
                        abort_run("count mismatch");
                end
        endtask

        task automatic check_line(input string name, input line_t exp, input line_t act);
                if (act !== exp) begin
                        $display("CHECK FAILED %s: expected %h, got %h", name, exp.flat, act.flat);
                        abort_run("written-back line differs from memory image");
                end
        endtask

        // returns on the accepting edge
        task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb);
                cur_addr = addr;
                i_cpu_req_valid <= 1'b1;
                i_cpu_req_we    <= we;
                i_cpu_req_addr  <= addr;
                i_cpu_req_wdata <= wdata;
                i_cpu_req_wstrb <= strb;
                do begin
                        @(posedge clk);
                end while (!o_cpu_req_ready);
                i_cpu_req_valid <= 1'b0;
        endtask

        task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb, output int lat);
                shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, strb);
                issue(1'b1, addr, data, strb);
                lat = 0;
                do begin
                        @(posedge clk);
                        lat++;
                end while (!o_cpu_req_ready);
        endtask

        task automatic cpu_read(input string name, input logic [31:0] addr, input int stall,
                                output int lat);
                logic [31:0] held;
                i_cpu_rsp_ready <= (stall == 0);
                issue(1'b0, addr, '0, '0);
                lat = 0;
                do begin
                        @(posedge clk);
                        lat++;
                end while (!o_cpu_rsp_valid);
                held = o_cpu_rsp_data;
                check_word(name, expected_word(addr), held);
                for (int i = 1; i <= stall; i++) begin
                        if (i == stall) i_cpu_rsp_ready <= 1'b1;
                        @(posedge clk);
                        if (!o_cpu_rsp_valid) abort_run("response valid dropped before ready");
                        check_word(name, held, o_cpu_rsp_data);  // must not move while held
                end
        endtask

        // refill burst must fetch the whole line of the request in flight
        always @(posedge clk) begin
                if (o_mem_rd_req_valid && i_mem_rd_req_ready) begin
                        check_word("read burst address", cur_addr & ~32'h1f, o_mem_rd_req_addr);
                end
        end

        // collects each write-back burst and compares it with the shadow
        always @(posedge clk) begin : wb_monitor
                line_t full;
                if (o_mem_wr_req_valid && i_mem_wr_req_ready) begin
                        wb_addr <= o_mem_wr_req_addr;
                        wb_beat <= '0;
                end
                if (o_mem_wr_data_valid && i_mem_wr_data_ready) begin
                        full = wb_line;
                        full.words[wb_beat] = o_mem_wr_data;
                        wb_line <= full;
                        wb_beat <= wb_beat + 1'b1;
                        if (o_mem_wr_data_last !== (wb_beat == 3'd7)) begin
                                abort_run("write-back last flag on the wrong beat");
                        end
                        if (wb_beat == 3'd7) begin
                                check_line("write-back line", shadow_line(wb_addr), full);
                                wb_count <= wb_count + 1;
                        end
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles > CYCLE_LIMIT) begin
                        abort_run($sformatf("timeout, run not done in %0d cycles", CYCLE_LIMIT));
                end
        end

        initial begin
                int          lat;
                int          rd0;
                int          st;
                logic [31:0] a;
                i_cpu_req_valid = 1'b0;
                i_cpu_req_we    = 1'b0;
                i_cpu_req_addr  = '0;
                i_cpu_req_wdata = '0;
                i_cpu_req_wstrb = '0;
                i_cpu_rsp_ready = 1'b0;
                seed = SEED;
                for (int i = 0; i < NUM_WORDS; i++) begin
                        shadow[i] = $random(seed);  // same sequence as the memory fill
                end
                @(posedge clk);
                while (rst) @(posedge clk);

                a = addr_of(0, 0, 3);
                rd0 = rd_count;
                cpu_read("read miss", a, 0, lat);
                check_count("read miss requests", rd0 + 1, rd_count);

                for (int w = 0; w < BEATS; w++) begin
                        cpu_read("read hit", addr_of(0, 0, w), 0, lat);
                        check_count("read hit latency", 3, lat);  // valid seen on third edge
                end

                for (int n = 0; n < 4; n++) begin
                        a = addr_of(0, 0, $random(seed) & 7);
                        cpu_write(a, $random(seed), 4'($random(seed)), lat);
                        check_count("write hit latency", 3, lat);
                        cpu_read("strobed write", a, 0, lat);
                end
                check_count("hit requests", rd0 + 1, rd_count);

                // five dirty lines in set 2, tag 0 is the oldest
                for (int t = 0; t < 5; t++) begin
                        if (t == 4) check_count("write-backs before fifth line", 0, wb_count);
                        cpu_write(addr_of(t, 2, t), $random(seed), 4'hf, lat);
                end
                check_count("write-backs after fifth line", 1, wb_count);
                check_word("write-back address", addr_of(0, 2, 0), wb_addr);
                for (int t = 0; t < 5; t++) begin
                        cpu_read("read after eviction", addr_of(t, 2, t), 0, lat);
                end

                // set 5: fill A..D, touch B..D, then E replaces A
                for (int t = 0; t < 4; t++) cpu_read("fill", addr_of(t, 5, 0), 0, lat);
                for (int t = 1; t < 4; t++) cpu_read("age", addr_of(t, 5, 0), 0, lat);
                cpu_read("replace", addr_of(4, 5, 0), 0, lat);
                rd0 = rd_count;
                for (int t = 1; t < 4; t++) cpu_read("survivor", addr_of(t, 5, 0), 0, lat);
                check_count("survivor requests", rd0, rd_count);
                cpu_read("evicted line", addr_of(0, 5, 0), 0, lat);
                check_count("evicted line requests", rd0 + 1, rd_count);

                for (int n = 0; n < 6; n++) begin
                        a = $random(seed) & 32'h7fc;
                        st = 1 + ($random(seed) & 7);
                        cpu_read("back-pressure", a, st, lat);
                end

                $display("Finished with no errors");
                $finish;
        end

endmodule

// File: testbench/tb_mem_model.sv
module tb_mem_model #(
        parameter int     NUM_LINES = 64,
        parameter int     STALL_PCT = 25,
        parameter integer SEED      = 0
) (
        input  logic        clk,
        input  logic        rst,
        input  logic        i_rd_req_valid,
        input  logic [31:0] i_rd_req_addr,
        output logic        o_rd_req_ready,
        output logic        o_rd_rsp_valid,
        output logic [31:0] o_rd_rsp_data,
        output logic        o_rd_rsp_last,
        input  logic        i_rd_rsp_ready,
        input  logic        i_wr_req_valid,
        input  logic [31:0] i_wr_req_addr,
        output logic        o_wr_req_ready,
        input  logic        i_wr_data_valid,
        input  logic [31:0] i_wr_data,
        output logic        o_wr_data_ready,
        output int          o_rd_count
);
        timeunit 1ns;
        timeprecision 100ps;

        localparam int LINE_W = $clog2(NUM_LINES);

        logic [31:0]       words [NUM_LINES*8];
        logic [3:0]        stall   = '0;    // rd req, rd data, wr req, wr data
        logic              rd_busy = 1'b0;
        logic              wr_busy = 1'b0;
        logic [LINE_W-1:0] rd_line = '0;
        logic [LINE_W-1:0] wr_line = '0;
        logic [2:0]        rd_beat = '0;
        logic [2:0]        wr_beat = '0;
        integer            seed;

        initial begin
                seed = SEED;
                for (int i = 0; i < NUM_LINES*8; i++) begin
                        words[i] = $random(seed);
                end
        end

        assign o_rd_req_ready  = !rd_busy && !stall[0];
        assign o_rd_rsp_valid  = rd_busy && !stall[1];
        assign o_rd_rsp_data   = words[{rd_line, rd_beat}];
        assign o_rd_rsp_last   = (rd_beat == 3'd7);
        assign o_wr_req_ready  = !wr_busy && !stall[2];
        assign o_wr_data_ready = wr_busy && !stall[3];

        always @(posedge clk) begin
                for (int k = 0; k < 4; k++) begin
                        stall[k] <= (($random(seed) & 32'h7fff_ffff) % 100) < STALL_PCT;
                end
                if (rst) begin
                        rd_busy    <= 1'b0;
                        wr_busy    <= 1'b0;
                        o_rd_count <= 0;
                end else begin
                        if (i_rd_req_valid && o_rd_req_ready) begin
                                rd_busy    <= 1'b1;
                                rd_line    <= i_rd_req_addr[5 +: LINE_W];
                                rd_beat    <= '0;
                                o_rd_count <= o_rd_count + 1;
                        end
                        if (o_rd_rsp_valid && i_rd_rsp_ready) begin
                                rd_beat <= rd_beat + 1'b1;
                                if (o_rd_rsp_last) rd_busy <= 1'b0;
                        end
                        if (i_wr_req_valid && o_wr_req_ready) begin
                                wr_busy <= 1'b1;
                                wr_line <= i_wr_req_addr[5 +: LINE_W];
                                wr_beat <= '0;
                        end
                        if (i_wr_data_valid && o_wr_data_ready) begin
                                words[{wr_line, wr_beat}] <= i_wr_data;
                                wr_beat <= wr_beat + 1'b1;
                                if (wr_beat == 3'd7) wr_busy <= 1'b0;  // full line stored
                        end
                end
        end

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
        parameter int RST_CYCLES = 4
) (
        output logic o_clk,
        output logic o_rst
);
        timeunit 1ns;
        timeprecision 100ps;

        initial begin
                o_clk = 1'b0;
                forever #5 o_clk = ~o_clk;  // 10 ns period
        end

        initial begin
                o_rst = 1'b1;
                repeat (RST_CYCLES) @(posedge o_clk);
                o_rst <= 1'b0;
        end

endmodule

// File: design/dcache_top.sv
module dcache_top #(
        parameter int LRU_CNT_W = 8
) (
        input  logic        clk,
        input  logic        rst,

        // cpu side
        input  logic        i_cpu_req_valid,
        input  logic        i_cpu_req_we,
        input  logic [31:0] i_cpu_req_addr,
        input  logic [31:0] i_cpu_req_wdata,
        input  logic [3:0]  i_cpu_req_wstrb,
        output logic        o_cpu_req_ready,
        output logic        o_cpu_rsp_valid,
        output logic [31:0] o_cpu_rsp_data,
        input  logic        i_cpu_rsp_ready,

        // memory read side
        output logic        o_mem_rd_req_valid,
        output logic [31:0] o_mem_rd_req_addr,
        input  logic        i_mem_rd_req_ready,
        input  logic        i_mem_rd_rsp_valid,
        input  logic [31:0] i_mem_rd_rsp_data,
        input  logic        i_mem_rd_rsp_last,
        output logic        o_mem_rd_rsp_ready,

        // memory write side, full-word bursts only
        output logic        o_mem_wr_req_valid,
        output logic [31:0] o_mem_wr_req_addr,
        input  logic        i_mem_wr_req_ready,
        output logic        o_mem_wr_data_valid,
        output logic [31:0] o_mem_wr_data,
        output logic        o_mem_wr_data_last,
        input  logic        i_mem_wr_data_ready
);

        way_if u_way_if ();

        dcache_ctrl u_ctrl (
                .clk                 (clk),
                .rst                 (rst),
                .i_cpu_req_valid     (i_cpu_req_valid),
                .i_cpu_req_we        (i_cpu_req_we),
                .i_cpu_req_addr      (i_cpu_req_addr),
                .i_cpu_req_wdata     (i_cpu_req_wdata),
                .i_cpu_req_wstrb     (i_cpu_req_wstrb),
                .o_cpu_req_ready     (o_cpu_req_ready),
                .o_cpu_rsp_valid     (o_cpu_rsp_valid),
                .o_cpu_rsp_data      (o_cpu_rsp_data),
                .i_cpu_rsp_ready     (i_cpu_rsp_ready),
                .o_mem_rd_req_valid  (o_mem_rd_req_valid),
                .o_mem_rd_req_addr   (o_mem_rd_req_addr),
                .i_mem_rd_req_ready  (i_mem_rd_req_ready),
                .i_mem_rd_rsp_valid  (i_mem_rd_rsp_valid),
                .i_mem_rd_rsp_data   (i_mem_rd_rsp_data),
                .i_mem_rd_rsp_last   (i_mem_rd_rsp_last),
                .o_mem_rd_rsp_ready  (o_mem_rd_rsp_ready),
                .o_mem_wr_req_valid  (o_mem_wr_req_valid),
                .o_mem_wr_req_addr   (o_mem_wr_req_addr),
                .i_mem_wr_req_ready  (i_mem_wr_req_ready),
                .o_mem_wr_data_valid (o_mem_wr_data_valid),
                .o_mem_wr_data       (o_mem_wr_data),
                .o_mem_wr_data_last  (o_mem_wr_data_last),
                .i_mem_wr_data_ready (i_mem_wr_data_ready),
                .way                 (u_way_if.ctrl_mp)
        );

        dcache_ways #(
                .LRU_CNT_W (LRU_CNT_W)
        ) u_ways (
                .clk (clk),
                .rst (rst),
                .way (u_way_if.ways_mp)
        );

endmodule

// File: design/dcache_ctrl.sv
module dcache_ctrl (
        input  logic        clk,
        input  logic        rst,

        // cpu request / response
        input  logic        i_cpu_req_valid,
        input  logic        i_cpu_req_we,
        input  logic [31:0] i_cpu_req_addr,
        input  logic [31:0] i_cpu_req_wdata,
        input  logic [3:0]  i_cpu_req_wstrb,
        output logic        o_cpu_req_ready,
        output logic        o_cpu_rsp_valid,
        output logic [31:0] o_cpu_rsp_data,
        input  logic        i_cpu_rsp_ready,

        // memory read
        output logic        o_mem_rd_req_valid,
        output logic [31:0] o_mem_rd_req_addr,
        input  logic        i_mem_rd_req_ready,
        input  logic        i_mem_rd_rsp_valid,
        input  logic [31:0] i_mem_rd_rsp_data,
        input  logic        i_mem_rd_rsp_last,
        output logic        o_mem_rd_rsp_ready,

        // memory write
        output logic        o_mem_wr_req_valid,
        output logic [31:0] o_mem_wr_req_addr,
        input  logic        i_mem_wr_req_ready,
        output logic        o_mem_wr_data_valid,
        output logic [31:0] o_mem_wr_data,
        output logic        o_mem_wr_data_last,
        input  logic        i_mem_wr_data_ready,

        way_if.ctrl_mp      way
);
        import dcache_pkg::*;

        localparam int BEAT_W = $clog2(BEATS);

        ctrl_state_t state_q;
        ctrl_state_t state_d;

        // registered request
        logic [31:0] req_addr_q;
        logic        req_we_q;
        logic [31:0] req_wdata_q;
        logic [3:0]  req_wstrb_q;

        logic [BEAT_W-1:0] beat_q;
        line_t             refill_q;
        logic [BEATS*32-1:0] rsp_shift;

        logic req_fire;
        logic rd_beat;
        logic wr_beat;

        assign req_fire = o_cpu_req_ready & i_cpu_req_valid;
        assign rd_beat  = o_mem_rd_rsp_ready & i_mem_rd_rsp_valid;
        assign wr_beat  = o_mem_wr_data_valid & i_mem_wr_data_ready;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state_q <= WAIT;
                end else begin
                        state_q <= state_d;
                end
        end

        always_comb begin
                state_d = state_q;  // hold on back-pressure
                case (state_q)
                WAIT:   if (i_cpu_req_valid) state_d = TAG_RD;
                TAG_RD: state_d = way.hit ? CACHE : EVICT;
                CACHE:  state_d = req_we_q ? WAIT : RESP;
                RESP:   if (i_cpu_rsp_ready) state_d = WAIT;
                EVICT:  state_d = way.victim_dirty ? MEM_WT : MEM_RD;
                MEM_WT: if (i_mem_wr_req_ready) state_d = SEND;
                SEND:   if (wr_beat && o_mem_wr_data_last) state_d = MEM_RD;
                MEM_RD: if (i_mem_rd_req_ready) state_d = RECV;
                RECV:   if (rd_beat && i_mem_rd_rsp_last) state_d = REFILL;
                REFILL: state_d = req_we_q ? CACHE : RESP;
                default: state_d = WAIT;
                endcase
        end

        always_ff @(posedge clk) begin
                if (req_fire) begin
                        req_addr_q  <= i_cpu_req_addr;
                        req_we_q    <= i_cpu_req_we;
                        req_wdata_q <= i_cpu_req_wdata;
                        req_wstrb_q <= i_cpu_req_wstrb;
                end
        end

        // beat counter, shared by write-back and refill
        always_ff @(posedge clk) begin
                if (rst) begin
                        beat_q <= '0;
                end else if (state_q == MEM_RD || state_q == MEM_WT) begin
                        beat_q <= '0;
                end else if (rd_beat || wr_beat) begin
                        beat_q <= beat_q + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (rd_beat) begin
                        refill_q.words[beat_q] <= i_mem_rd_rsp_data;
                end
        end

        // handshake levels straight from the state
        assign o_cpu_req_ready     = (state_q == WAIT);
        assign o_cpu_rsp_valid     = (state_q == RESP);
        assign o_mem_rd_req_valid  = (state_q == MEM_RD);
        assign o_mem_rd_rsp_ready  = (state_q == RECV);
        assign o_mem_wr_req_valid  = (state_q == MEM_WT);
        assign o_mem_wr_data_valid = (state_q == SEND);

        assign o_mem_rd_req_addr = {req_addr_q[31:OFFSET_W], {OFFSET_W{1'b0}}};
        assign o_mem_wr_req_addr = {way.victim_tag, way.index, {OFFSET_W{1'b0}}};

        assign o_mem_wr_data      = way.victim_line.words[beat_q];
        assign o_mem_wr_data_last = (beat_q == BEAT_W'(BEATS - 1));

        assign rsp_shift      = way.hit_line.flat >> {way.offset, 3'b000};
        assign o_cpu_rsp_data = rsp_shift[31:0];

        // request fields to the ways
        assign way.tag         = req_addr_q[31 -: TAG_W];
        assign way.index       = req_addr_q[OFFSET_W +: INDEX_W];
        assign way.offset      = req_addr_q[OFFSET_W-1:0];
        assign way.wdata       = req_wdata_q;
        assign way.wstrb       = req_wstrb_q;
        assign way.refill_line = refill_q;

        assign way.lookup = (state_q == TAG_RD);
        assign way.store  = (state_q == CACHE) & req_we_q;
        assign way.evict  = (state_q == EVICT);
        assign way.refill = (state_q == REFILL);
        assign way.age    = (state_q == CACHE);

        // response held until the cpu takes it
        assert property (@(posedge clk) disable iff (rst)
                o_cpu_rsp_valid && !i_cpu_rsp_ready |=>
                        o_cpu_rsp_valid && $stable(o_cpu_rsp_data))
                else $error("cpu response dropped or changed before ready");

endmodule

// File: design/dcache_ways.sv
module dcache_ways #(
        parameter int LRU_CNT_W = 8
) (
        input  logic   clk,
        input  logic   rst,
        way_if.ways_mp way
);
        import dcache_pkg::*;

        // tag and data storage
        logic [TAG_W-1:0] tag_mem  [NUM_WAYS][NUM_SETS];
        line_t            data_mem [NUM_WAYS][NUM_SETS];

        logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
        logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];

        logic [NUM_WAYS-1:0] hit_way;   // one-hot
        logic [NUM_WAYS-1:0] set_valid;
        way_sel_t            hit_num;
        way_sel_t            lru_victim;
        way_sel_t            victim_q;  // frozen for the whole miss

        logic [31:0]         strb_bits;
        logic [BEATS*32-1:0] wmask;
        logic [BEATS*32-1:0] wshift;
        line_t               merged;

        always_comb begin
                hit_num = '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                        set_valid[w] = valid_q[w][way.index];
                        hit_way[w]   = set_valid[w] && (tag_mem[w][way.index] == way.tag);
                        if (hit_way[w]) hit_num = way_sel_t'(w);
                end
        end

        assign way.hit          = |hit_way;
        assign way.hit_line     = data_mem[hit_num][way.index];
        assign way.victim_tag   = tag_mem[victim_q][way.index];
        assign way.victim_line  = data_mem[victim_q][way.index];
        assign way.victim_dirty = dirty_q[victim_q][way.index] & valid_q[victim_q][way.index];

        // byte merge of the store into the hit line
        always_comb begin
                for (int b = 0; b < 4; b++) begin
                        strb_bits[8*b +: 8] = {8{way.wstrb[b]}};
                end
        end

        assign wmask       = {{(BEATS*32-32){1'b0}}, strb_bits} << {way.offset, 3'b000};
        assign wshift      = {{(BEATS*32-32){1'b0}}, way.wdata} << {way.offset, 3'b000};
        assign merged.flat = (wshift & wmask) | (way.hit_line.flat & ~wmask);

        always_ff @(posedge clk) begin
                if (way.lookup) begin
                        victim_q <= lru_victim;
                end
        end

        always_ff @(posedge clk) begin
                if (way.refill) begin
                        data_mem[victim_q][way.index] <= way.refill_line;
                        tag_mem[victim_q][way.index]  <= way.tag;
                end else if (way.store) begin
                        data_mem[hit_num][way.index] <= merged;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int w = 0; w < NUM_WAYS; w++) begin
                                valid_q[w] <= '0;
                                dirty_q[w] <= '0;
                        end
                end else if (way.evict) begin
                        valid_q[victim_q][way.index] <= 1'b0;
                end else if (way.refill) begin
                        valid_q[victim_q][way.index] <= 1'b1;  // fresh line is clean
                        dirty_q[victim_q][way.index] <= 1'b0;
                end else if (way.store) begin
                        dirty_q[hit_num][way.index] <= 1'b1;
                end
        end

        lru_policy #(
                .LRU_CNT_W (LRU_CNT_W)
        ) u_lru (
                .clk       (clk),
                .rst       (rst),
                .i_index   (way.index),
                .i_hit_way (hit_way),
                .i_age     (way.age),
                .i_refill  (way.refill),
                .i_valid   (set_valid),
                .o_victim  (lru_victim)
        );

        assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
                else $error("tag match in more than one way");

        // controller only stores after a hit was seen
        assert property (@(posedge clk) disable iff (rst) way.store |-> way.hit)
                else $error("store without a hit");

endmodule

// File: design/lru_policy.sv
module lru_policy #(
        parameter int LRU_CNT_W = 8
) (
        input  logic                           clk,
        input  logic                           rst,
        input  logic [dcache_pkg::INDEX_W-1:0] i_index,
        input  logic [3:0]                     i_hit_way,
        input  logic                           i_age,
        input  logic                           i_refill,
        input  logic [3:0]                     i_valid,
        output dcache_pkg::way_sel_t           o_victim
);
        import dcache_pkg::*;

        logic [LRU_CNT_W-1:0] age_q [NUM_SETS][NUM_WAYS];
        way_sel_t             oldest;

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int s = 0; s < NUM_SETS; s++) begin
                                for (int w = 0; w < NUM_WAYS; w++) begin
                                        age_q[s][w] <= '0;
                                end
                        end
                end else if (i_age) begin
                        for (int w = 0; w < NUM_WAYS; w++) begin
                                // saturate, never wrap back to young
                                if (!i_hit_way[w] && !(&age_q[i_index][w])) begin
                                        age_q[i_index][w] <= age_q[i_index][w] + 1'b1;
                                end
                        end
                end else if (i_refill) begin
                        age_q[i_index][o_victim] <= '0;
                end
        end

        always_comb begin
                oldest = '0;
                for (int w = 1; w < NUM_WAYS; w++) begin
                        if (age_q[i_index][w] > age_q[i_index][oldest]) oldest = way_sel_t'(w);
                end
                o_victim = oldest;
                for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                        if (!i_valid[w]) o_victim = way_sel_t'(w);  // lowest empty way wins
                end
        end

endmodule

// File: design/way_if.sv
interface way_if;
        import dcache_pkg::*;

        // request fields, from the controller
        logic [INDEX_W-1:0]  index;
        logic [TAG_W-1:0]    tag;
        logic [OFFSET_W-1:0] offset;
        logic [31:0]         wdata;
        logic [3:0]          wstrb;
        line_t               refill_line;

        // strobes, one per controller state
        logic lookup;   // TAG_RD
        logic store;    // CACHE on a write
        logic evict;    // EVICT
        logic refill;   // REFILL
        logic age;      // CACHE

        // lookup results, from the ways
        logic               hit;
        line_t              hit_line;
        logic               victim_dirty;
        logic [TAG_W-1:0]   victim_tag;
        line_t              victim_line;

        modport ctrl_mp (
                output index, tag, offset, wdata, wstrb, refill_line,
                output lookup, store, evict, refill, age,
                input  hit, hit_line, victim_dirty, victim_tag, victim_line
        );

        modport ways_mp (
                input  index, tag, offset, wdata, wstrb, refill_line,
                input  lookup, store, evict, refill, age,
                output hit, hit_line, victim_dirty, victim_tag, victim_line
        );

endinterface

// File: design/dcache_pkg.sv
package dcache_pkg;

        // address split
        localparam int TAG_W    = 24;
        localparam int INDEX_W  = 3;
        localparam int OFFSET_W = 5;

        // geometry
        localparam int NUM_WAYS = 4;
        localparam int NUM_SETS = 8;
        localparam int BEATS    = 8;    // 32-bit words per line

        // one cache line, seen as beats or as a flat vector
        typedef union packed {
                logic [BEATS*32-1:0]      flat;
                logic [BEATS-1:0][31:0]   words;  // word 0 in the low bits
        } line_t;

        typedef logic [1:0] way_sel_t;

        typedef enum logic [3:0] {
                WAIT,
                TAG_RD,
                CACHE,
                RESP,
                EVICT,
                MEM_WT,
                SEND,
                MEM_RD,
                RECV,
                REFILL
        } ctrl_state_t;

endpackage
